//--- hw/fixPkg.sv
package fixPkg;

  localparam int FIX_W = 18;
  localparam int WIDE_W = 22;  // Room for a sum of four words and its negation

  typedef logic signed [FIX_W-1:0] fix_t;
  typedef logic signed [WIDE_W-1:0] wide_t;

  localparam fix_t FIX_MAX = 18'sh1ffff;
  localparam fix_t FIX_MIN = 18'sh20000;

  // Clamp a wide sum back to one word
  function automatic fix_t satWide(input wide_t x);
    if (x > FIX_MAX) begin
      return FIX_MAX;
    end
    if (x < FIX_MIN) begin
      return FIX_MIN;
    end
    return x[FIX_W-1:0];
  endfunction

endpackage

//--- hw/renderPkg.sv
package renderPkg;

  import fixPkg::*;

  typedef struct packed {
    fix_t x;
    fix_t y;
    fix_t z;
  } vec3_t;

  // Indexed as [row][col], columns u, v, n scaled, then n
  typedef fix_t [3:0][3:0] camMatrix_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DIV_DH,
    S_DIV_FFD,
    S_SCALE,
    S_TRANSLATE
  } setupState_e;

  typedef enum logic [1:0] {
    P_IDLE,
    P_SUM,
    P_DIVIDE
  } projState_e;

endpackage

//--- hw/divIf.sv
`timescale 1ns/10ps
interface divIf import fixPkg::*; ();

  logic start;     // Operands sampled here
  fix_t dividend;
  fix_t divisor;
  logic done;
  fix_t quotient;  // Holds until next start

  modport ctrl (
    output start, dividend, divisor,
    input  done, quotient
  );

  modport unit (
    input  start, dividend, divisor,
    output done, quotient
  );

endinterface

//--- hw/camMatrixIf.sv
`timescale 1ns/10ps
interface camMatrixIf import renderPkg::*; ();

  camMatrix_t mat;
  logic matValid;  // Low while a new camera is built

  modport src (
    output mat,
    output matValid
  );

  modport dst (
    input mat,
    input matValid
  );

endinterface

//--- hw/fixMultiplier.sv
`timescale 1ns/10ps
module fixMultiplier import fixPkg::*; #(
  parameter int FRAC_BITS = 9
) (
  input  fix_t a,
  input  fix_t b,
  output fix_t product
);

  logic signed [2*FIX_W-1:0] full;
  logic signed [2*FIX_W-1:0] scaled;

  assign full = a * b;
  assign scaled = full >>> FRAC_BITS;  // Back to FRAC_BITS fraction

  always_comb begin
    if (scaled > FIX_MAX) begin
      product = FIX_MAX;
    end else if (scaled < FIX_MIN) begin
      product = FIX_MIN;
    end else begin
      product = scaled[FIX_W-1:0];
    end
  end

endmodule

//--- hw/fixDivider.sv
`timescale 1ns/10ps
module fixDivider import fixPkg::*; #(
  parameter int FRAC_BITS = 9
) (
  input logic clk,
  input logic arstN,
  divIf.unit  div
);

  localparam int NW = FIX_W + FRAC_BITS;  // Shifted dividend width, one bit per cycle
  localparam int CW = $clog2(NW + 1);

  logic [NW-1:0] quo;
  logic [NW-1:0] quoNext;
  logic [FIX_W-1:0] rem;
  logic [FIX_W-1:0] remNext;
  logic [FIX_W-1:0] dvs;
  logic [FIX_W:0] remShift;
  logic [FIX_W+1:0] trial;
  logic [CW-1:0] cnt;
  logic negRes;
  logic numNeg;
  logic dvsZero;
  fix_t result;

  function automatic logic [FIX_W-1:0] magnitude(input fix_t x);
    return x[FIX_W-1] ? FIX_W'(-x) : FIX_W'(x);
  endfunction

  // One restoring step
  always_comb begin
    remShift = {rem, quo[NW-1]};
    trial = {1'b0, remShift} - {2'b00, dvs};
    if (trial[FIX_W+1]) begin
      remNext = remShift[FIX_W-1:0];
      quoNext = {quo[NW-2:0], 1'b0};
    end else begin
      remNext = trial[FIX_W-1:0];
      quoNext = {quo[NW-2:0], 1'b1};
    end
  end

  always_comb begin
    if (dvsZero) begin
      result = numNeg ? FIX_MIN : FIX_MAX;  // 0/0 lands on FIX_MAX
    end else if (negRes) begin
      if (|quoNext[NW-1:FIX_W] || (quoNext[FIX_W-1] && |quoNext[FIX_W-2:0])) begin
        result = FIX_MIN;
      end else begin
        result = -$signed(quoNext[FIX_W-1:0]);
      end
    end else if (|quoNext[NW-1:FIX_W-1]) begin
      result = FIX_MAX;
    end else begin
      result = $signed(quoNext[FIX_W-1:0]);
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cnt <= '0;
      div.done <= 1'b0;
    end else begin
      div.done <= 1'b0;
      if (div.start) begin
        cnt <= CW'(NW);
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == CW'(1)) begin
          div.done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div.start) begin
      quo <= {magnitude(div.dividend), {FRAC_BITS{1'b0}}};
      rem <= '0;
      dvs <= magnitude(div.divisor);
      negRes <= div.dividend[FIX_W-1] ^ div.divisor[FIX_W-1];
      numNeg <= div.dividend[FIX_W-1];
      dvsZero <= (div.divisor == '0);
    end else if (cnt != '0) begin
      quo <= quoNext;
      rem <= remNext;
      if (cnt == CW'(1)) begin
        div.quotient <= result;
      end
    end
  end

endmodule

//--- hw/cameraMatrixSetup.sv
`timescale 1ns/10ps
module cameraMatrixSetup import fixPkg::*; import renderPkg::*; #(
  parameter int FRAC_BITS = 9
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    camLoad,
  input  vec3_t   lookFrom,
  input  vec3_t   u,
  input  vec3_t   v,
  input  vec3_t   n,
  input  fix_t    near,
  input  fix_t    far,
  input  fix_t    height,
  camMatrixIf.src cam
);

  setupState_e state;
  vec3_t lfR;
  vec3_t uR;
  vec3_t vR;
  vec3_t nR;
  fix_t dR;
  fix_t fR;
  fix_t dhR;    // D/H
  fix_t ffdR;   // F/(F-D)
  fix_t dffdR;  // D*F/(F-D)
  camMatrix_t matR;
  logic validR;
  fix_t lfArr [3];
  fix_t basis [3][3];
  fix_t mulA [9];
  fix_t mulB [9];
  fix_t mulP [9];
  wide_t colSum [3];

  divIf divBus ();

  // First division takes its operands straight from the ports
  assign divBus.start = (state == S_IDLE && camLoad) || (state == S_DIV_DH && divBus.done);
  assign divBus.dividend = (state == S_IDLE) ? near : fR;
  assign divBus.divisor = (state == S_IDLE) ? height : fR - dR;

  fixDivider #(.FRAC_BITS(FRAC_BITS)) uDiv (.clk, .arstN, .div(divBus));

  assign lfArr = '{lfR.x, lfR.y, lfR.z};
  assign basis = '{'{uR.x, uR.y, uR.z}, '{vR.x, vR.y, vR.z}, '{nR.x, nR.y, nR.z}};

  always_comb begin
    for (int c = 0; c < 3; c++) begin
      for (int r = 0; r < 3; r++) begin
        mulA[3*c+r] = basis[c][r];
        mulB[3*c+r] = (c == 2) ? ffdR : dhR;
        if (state == S_TRANSLATE) begin
          mulA[3*c+r] = lfArr[r];
          mulB[3*c+r] = matR[r][c];
        end
      end
    end
    if (state == S_DIV_FFD) begin  // lookFrom.n and D*F/(F-D) while waiting
      for (int r = 0; r < 3; r++) begin
        mulA[r] = lfArr[r];
        mulB[r] = basis[2][r];
      end
      mulA[3] = dR;
      mulB[3] = divBus.quotient;
    end
    for (int c = 0; c < 3; c++) begin
      colSum[c] = mulP[3*c] + mulP[3*c+1] + mulP[3*c+2];
    end
  end

  for (genvar i = 0; i < 9; i++) begin : gMul
    fixMultiplier #(.FRAC_BITS(FRAC_BITS)) uMul (.a(mulA[i]), .b(mulB[i]), .product(mulP[i]));
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= S_IDLE;
      validR <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (camLoad) begin
            state <= S_DIV_DH;
            validR <= 1'b0;
          end
        end
        S_DIV_DH: begin
          if (divBus.done) begin
            state <= S_DIV_FFD;
          end
        end
        S_DIV_FFD: begin
          if (divBus.done) begin
            state <= S_SCALE;
          end
        end
        S_SCALE: state <= S_TRANSLATE;
        S_TRANSLATE: begin
          state <= S_IDLE;
          validR <= 1'b1;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && camLoad) begin
      lfR <= lookFrom;
      uR <= u;
      vR <= v;
      nR <= n;
      dR <= near;
      fR <= far;
    end
    if (state == S_DIV_DH && divBus.done) begin
      dhR <= divBus.quotient;
    end
    if (state == S_DIV_FFD && divBus.done) begin
      ffdR <= divBus.quotient;
      dffdR <= mulP[3];
      matR[3][3] <= satWide(-colSum[0]);
    end
    if (state == S_SCALE) begin
      for (int c = 0; c < 3; c++) begin
        for (int r = 0; r < 3; r++) begin
          matR[r][c] <= mulP[3*c+r];
        end
      end
      for (int r = 0; r < 3; r++) begin
        matR[r][3] <= basis[2][r];  // Column 3 is n itself
      end
    end
    if (state == S_TRANSLATE) begin
      matR[3][0] <= satWide(-colSum[0]);
      matR[3][1] <= satWide(-colSum[1]);
      matR[3][2] <= satWide(-(colSum[2] + dffdR));
    end
  end

  assign cam.mat = matR;
  assign cam.matValid = validR;

endmodule

//--- hw/vertexProjector.sv
`timescale 1ns/10ps
module vertexProjector import fixPkg::*; import renderPkg::*; #(
  parameter int FRAC_BITS = 9
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    vtxStart,
  input  vec3_t   vtx,
  camMatrixIf.dst cam,
  output logic    vtxBusy,
  output logic    outValid,
  output vec3_t   screen,
  output logic    outClip
);

  projState_e state;
  vec3_t vtxR;
  logic accept;
  logic clipPend;
  fix_t vArr [3];
  fix_t prod [12];
  wide_t wideSum [4];
  fix_t sums [4];  // xs, ys, zs, w

  divIf divBus [3] ();

  assign accept = vtxStart && !vtxBusy && cam.matValid;
  assign vtxBusy = (state != P_IDLE);
  assign vArr = '{vtxR.x, vtxR.y, vtxR.z};

  for (genvar c = 0; c < 4; c++) begin : gCol
    for (genvar r = 0; r < 3; r++) begin : gRow
      fixMultiplier #(.FRAC_BITS(FRAC_BITS)) uMul (
        .a(vArr[r]),
        .b(cam.mat[r][c]),
        .product(prod[3*c+r])
      );
    end
    assign wideSum[c] = prod[3*c] + prod[3*c+1] + prod[3*c+2] + cam.mat[3][c];
    assign sums[c] = satWide(wideSum[c]);
  end

  // Dividers capture the sums during SUM
  for (genvar i = 0; i < 3; i++) begin : gDiv
    assign divBus[i].start = (state == P_SUM);
    assign divBus[i].dividend = sums[i];
    assign divBus[i].divisor = sums[3];
    fixDivider #(.FRAC_BITS(FRAC_BITS)) uDiv (.clk, .arstN, .div(divBus[i]));
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= P_IDLE;
      outValid <= 1'b0;
    end else begin
      outValid <= 1'b0;
      case (state)
        P_IDLE: begin
          if (accept) begin
            state <= P_SUM;
          end
        end
        P_SUM: state <= P_DIVIDE;
        P_DIVIDE: begin
          if (divBus[0].done) begin  // All three finish together
            state <= P_IDLE;
            outValid <= 1'b1;
          end
        end
        default: state <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      vtxR <= vtx;
    end
    if (state == P_SUM) begin
      clipPend <= (sums[3] <= fix_t'(0));
    end
    if (state == P_DIVIDE && divBus[0].done) begin
      screen <= '{x: divBus[0].quotient, y: divBus[1].quotient, z: divBus[2].quotient};
      outClip <= clipPend;
    end
  end

endmodule

//--- hw/screenProjector.sv
`timescale 1ns/10ps
module screenProjector import fixPkg::*; import renderPkg::*; #(
  parameter int FRAC_BITS = 9
) (
  input  logic  clk,
  input  logic  arstN,
  input  logic  camLoad,
  input  vec3_t lookFrom,
  input  vec3_t u,
  input  vec3_t v,
  input  vec3_t n,
  input  fix_t  near,
  input  fix_t  far,
  input  fix_t  height,
  output logic  camReady,
  input  logic  vtxStart,
  input  vec3_t vtx,
  output logic  vtxBusy,
  output logic  outValid,
  output vec3_t screen,
  output logic  outClip
);

  camMatrixIf camBus ();

  cameraMatrixSetup #(.FRAC_BITS(FRAC_BITS)) uSetup (
    .clk,
    .arstN,
    .camLoad,
    .lookFrom,
    .u,
    .v,
    .n,
    .near,
    .far,
    .height,
    .cam(camBus)
  );

  vertexProjector #(.FRAC_BITS(FRAC_BITS)) uProj (
    .clk,
    .arstN,
    .vtxStart,
    .vtx,
    .cam(camBus),
    .vtxBusy,
    .outValid,
    .screen,
    .outClip
  );

  assign camReady = camBus.matValid;

endmodule

//--- verif/tbScreenProjector.sv
`timescale 1ns/10ps
module tbScreenProjector import fixPkg::*; import renderPkg::*; ();

  localparam int FRAC_BITS = 9;
  localparam int DIV_CYCLES = 18 + FRAC_BITS + 1;
  localparam int LOAD_CYCLES = 2 * DIV_CYCLES + 3;
  localparam int VTX_CYCLES = DIV_CYCLES + 2;
  localparam int TIMEOUT = 4 * DIV_CYCLES;

  logic clk;
  logic arstN;
  logic camLoad;
  vec3_t lookFrom;
  vec3_t u;
  vec3_t v;
  vec3_t n;
  fix_t near;
  fix_t far;
  fix_t height;
  logic camReady;
  logic vtxStart;
  vec3_t vtx;
  logic vtxBusy;
  logic outValid;
  vec3_t screen;
  logic outClip;

  int errCount = 0;
  int timeoutCount = 0;
  logic [31:0] rngState = 32'hfcca;
  camMatrix_t expMat;  // Model of the loaded camera

  screenProjector #(.FRAC_BITS(FRAC_BITS)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic fix_t satFix(input longint x);
    if (x > FIX_MAX) return FIX_MAX;
    if (x < FIX_MIN) return FIX_MIN;
    return fix_t'(x);
  endfunction

  function automatic fix_t fixMul(input fix_t a, input fix_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return satFix(p >>> FRAC_BITS);
  endfunction

  function automatic fix_t fixDiv(input fix_t a, input fix_t b);
    longint num;
    if (b == 0) return (a < 0) ? FIX_MIN : FIX_MAX;
    num = longint'(a) * (longint'(1) << FRAC_BITS);
    return satFix(num / longint'(b));  // Truncates toward zero
  endfunction

  function automatic fix_t fixOf(input real r);
    return fix_t'($rtoi(r * (1 << FRAC_BITS)));
  endfunction

  function automatic vec3_t mkVec(input real x, input real y, input real z);
    vec3_t r;
    r.x = fixOf(x);
    r.y = fixOf(y);
    r.z = fixOf(z);
    return r;
  endfunction

  function automatic fix_t elem(input vec3_t p, input int i);
    case (i)
      0: return p.x;
      1: return p.y;
      default: return p.z;
    endcase
  endfunction

  function automatic camMatrix_t buildMatrix(input vec3_t lf, input vec3_t bu, input vec3_t bv,
                                             input vec3_t bn, input fix_t d, input fix_t f,
                                             input fix_t h);
    camMatrix_t m;
    vec3_t cols [3];
    fix_t dh;
    fix_t ffd;
    fix_t dffd;
    longint acc;
    cols[0] = bu;
    cols[1] = bv;
    cols[2] = bn;
    dh = fixDiv(d, h);
    ffd = fixDiv(f, fix_t'(f - d));
    dffd = fixMul(d, ffd);
    for (int c = 0; c < 3; c++) begin
      for (int r = 0; r < 3; r++) begin
        m[r][c] = fixMul(elem(cols[c], r), (c == 2) ? ffd : dh);
      end
    end
    for (int r = 0; r < 3; r++) begin
      m[r][3] = elem(bn, r);
    end
    for (int c = 0; c < 4; c++) begin
      acc = 0;
      for (int r = 0; r < 3; r++) begin
        acc += fixMul(elem(lf, r), m[r][c]);
      end
      if (c == 2) acc += dffd;  // Near plane offset
      m[3][c] = satFix(-acc);
    end
    return m;
  endfunction

  task automatic modelProject(input vec3_t p, output vec3_t s, output logic clip);
    fix_t sums [4];
    longint acc;
    for (int c = 0; c < 4; c++) begin
      acc = expMat[3][c];
      for (int r = 0; r < 3; r++) begin
        acc += fixMul(elem(p, r), expMat[r][c]);
      end
      sums[c] = satFix(acc);
    end
    s.x = fixDiv(sums[0], sums[3]);
    s.y = fixDiv(sums[1], sums[3]);
    s.z = fixDiv(sums[2], sums[3]);
    clip = (sums[3] <= 0);
  endtask

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic fix_t randFix();
    logic [31:0] r;
    r = nextRand();
    if (r[31]) return fix_t'(r[17:0]);  // Full range, often saturates
    return fix_t'($signed(r[13:0]));
  endfunction

  task automatic checkVec(input string name, input vec3_t got, input vec3_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got (%h,%h,%h), expected (%h,%h,%h)", name,
               got.x, got.y, got.z, exp.x, exp.y, exp.z);
      errCount++;
    end
  endtask

  task automatic checkFix(input string name, input fix_t got, input fix_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("[FAIL] %s: got %h cycles, expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic loadCamera(input vec3_t lf, input vec3_t bu, input vec3_t bv, input vec3_t bn,
                            input fix_t d, input fix_t f, input fix_t h);
    int cnt;
    lookFrom = lf;
    u = bu;
    v = bv;
    n = bn;
    near = d;
    far = f;
    height = h;
    camLoad = 1'b1;
    cnt = 0;
    while (cnt < TIMEOUT && !(cnt > 0 && camReady)) begin
      @(negedge clk);
      cnt++;
      if (cnt == 1) begin
        camLoad = 1'b0;
        checkBit("camReady", camReady, 1'b0);
      end
    end
    if (!camReady) begin
      $display("Timeout: camReady did not rise after camLoad");
      timeoutCount++;
    end else begin
      checkCount("camera load latency", cnt, LOAD_CYCLES);
    end
    expMat = buildMatrix(lf, bu, bv, bn, d, f, h);
  endtask

  task automatic runVertex(input vec3_t p);
    vec3_t expS;
    logic expClip;
    int cnt;
    modelProject(p, expS, expClip);
    vtx = p;
    vtxStart = 1'b1;
    cnt = 0;
    while (cnt < TIMEOUT && !(cnt > 0 && outValid)) begin
      @(negedge clk);
      cnt++;
      if (cnt == 1) begin
        vtxStart = 1'b0;
        checkBit("vtxBusy", vtxBusy, 1'b1);
      end
    end
    if (!outValid) begin
      $display("Timeout: outValid did not pulse for a vertex");
      timeoutCount++;
    end else begin
      checkCount("vertex latency", cnt, VTX_CYCLES);
      checkBit("vtxBusy", vtxBusy, 1'b0);
      checkVec("screen", screen, expS);
      checkBit("outClip", outClip, expClip);
    end
  endtask

  // Second start lands while the first vertex is in flight
  task automatic busyStartIgnored(input vec3_t p, input vec3_t other);
    vec3_t expS;
    logic expClip;
    int cnt;
    int pulses;
    modelProject(p, expS, expClip);
    vtx = p;
    vtxStart = 1'b1;
    cnt = 0;
    pulses = 0;
    while (cnt < VTX_CYCLES + DIV_CYCLES + 10) begin
      @(negedge clk);
      cnt++;
      vtxStart = (cnt == 5);
      if (cnt == 5) vtx = other;
      if (outValid) begin
        pulses++;
        if (pulses == 1) begin
          checkCount("vertex latency", cnt, VTX_CYCLES);
          checkVec("screen", screen, expS);
          checkBit("outClip", outClip, expClip);
        end
      end
    end
    if (pulses != 1) begin
      $display("A start while busy was not ignored, saw %0d result pulses", pulses);
      errCount++;
    end
  endtask

  task automatic startWithoutCamera();
    int cnt;
    vtx = mkVec(1.0, 1.0, 1.0);
    vtxStart = 1'b1;
    for (cnt = 0; cnt < TIMEOUT; cnt++) begin
      @(negedge clk);
      vtxStart = 1'b0;
      if (outValid || vtxBusy) begin
        $display("A vertex was accepted before any camera was loaded");
        errCount++;
        break;
      end
    end
  endtask

  initial begin
    vec3_t p;
    arstN = 1'b0;
    camLoad = 1'b0;
    vtxStart = 1'b0;
    lookFrom = '0;
    u = '0;
    v = '0;
    n = '0;
    near = '0;
    far = '0;
    height = '0;
    vtx = '0;
    repeat (3) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    checkBit("camReady", camReady, 1'b0);
    checkBit("vtxBusy", vtxBusy, 1'b0);
    checkBit("outValid", outValid, 1'b0);

    startWithoutCamera();

    loadCamera(mkVec(0.0, 0.0, 0.0), mkVec(1.0, 0.0, 0.0), mkVec(0.0, 1.0, 0.0),
               mkVec(0.0, 0.0, 1.0), fixOf(1.0), fixOf(10.0), fixOf(2.0));
    runVertex(mkVec(1.0, 2.0, 4.0));
    runVertex(mkVec(-3.0, 1.5, 8.0));
    runVertex(mkVec(0.5, -0.25, 2.0));
    runVertex(mkVec(10.0, -10.0, 1.0));

    runVertex(mkVec(1.0, 1.0, 0.0));  // w is zero
    checkBit("outClip", outClip, 1'b1);
    checkFix("screen.x", screen.x, FIX_MAX);
    checkFix("screen.z", screen.z, FIX_MIN);
    runVertex(mkVec(0.0, 0.0, 0.0));
    checkFix("screen.x", screen.x, FIX_MAX);
    runVertex(mkVec(2.0, -1.0, -4.0));  // Behind the eye
    checkBit("outClip", outClip, 1'b1);

    busyStartIgnored(mkVec(1.5, -2.0, 3.0), mkVec(-7.0, 5.0, 1.0));

    loadCamera(mkVec(1.5, -2.25, 3.0), mkVec(0.8, 0.0, -0.6), mkVec(0.1, 0.95, 0.2),
               mkVec(0.6, -0.3, 0.75), fixOf(0.75), fixOf(20.0), fixOf(1.5));
    for (int i = 0; i < 24; i++) begin
      p.x = randFix();
      p.y = randFix();
      p.z = randFix();
      runVertex(p);
    end

    loadCamera(mkVec(0.0, 0.0, 0.0), mkVec(1.0, 0.0, 0.0), mkVec(0.0, 1.0, 0.0),
               mkVec(0.0, 0.0, 1.0), fixOf(1.0), fixOf(10.0), fixOf(2.0));
    runVertex(mkVec(1.0, 2.0, 4.0));
    runVertex(mkVec(-3.0, 1.5, 8.0));

    $display("Errors: %0d mismatches, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/fixPkg.sv
hw/renderPkg.sv
hw/divIf.sv
hw/camMatrixIf.sv
hw/fixMultiplier.sv
hw/fixDivider.sv
hw/cameraMatrixSetup.sv
hw/vertexProjector.sv
hw/screenProjector.sv
verif/tbScreenProjector.sv
